// File: include/fsrc_seq_config.svh
/*
 * Fixed widths, identification words and register word addresses of the
 * sample-rate-change sequencer. Include this header in any file that needs
 * one of these values. The package takes its type widths from here.
 */
`ifndef FSRC_SEQ_CONFIG_SVH
`define FSRC_SEQ_CONFIG_SVH

// ******************************
// Datapath widths
// ******************************
`define FSRC_CTRL_WIDTH     40
`define FSRC_COUNTER_WIDTH  4
`define FSRC_NUM_TRIG       4

// Identification words returned by the register map
`define FSRC_CORE_VERSION   32'h00000100
`define FSRC_CORE_MAGIC     32'h46534551

// ******************************
// Register word addresses
// ******************************
`define REG_VERSION          14'h000
`define REG_MAGIC            14'h001
`define REG_SCRATCH          14'h002
`define REG_CONTROL          14'h010
`define REG_START            14'h011
`define REG_CTRL_CHANGE_CNT  14'h012
`define REG_ACCUM_RESET_CNT  14'h013
`define REG_RX_DELAY_CNT     14'h014
`define REG_TRIG_MANUAL      14'h015
`define REG_FIRST_TRIG_BASE  14'h018
`define REG_NEXT_CTRL_LO     14'h020
`define REG_NEXT_CTRL_HI     14'h021
`define REG_STATUS           14'h030

`endif

// File: src/fsrc_seq_pkg.sv
/*
 * Shared types of the sequencer. Every design file refers to them by
 * scoped name, so the package is compiled before the modules.
 */
`default_nettype none

`include "fsrc_seq_config.svh"

package fsrc_seq_pkg;

  // ******************************
  // Register bus types
  // ******************************

  // Word address of the register bus
  typedef logic [13:0] up_addr_t;

  // Read and write data of the register bus
  typedef logic [31:0] up_data_t;

  // ******************************
  // Sequencer types
  // ******************************

  // Event counter and every programmed event offset
  typedef logic [`FSRC_COUNTER_WIDTH-1:0] seq_cnt_t;

  // One bit for each trigger output
  typedef logic [`FSRC_NUM_TRIG-1:0] trig_vec_t;

  // Control word that is staged and then loaded onto ctrl
  typedef logic [`FSRC_CTRL_WIDTH-1:0] ctrl_word_t;

  // Controller states, idle then waiting for the timing event then counting
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_ARMED, SEQ_RUN} seq_state_t;

endpackage

`default_nettype wire

// File: src/fsrc_seq_regmap.sv
/*
 * Register file of the sequencer on the request/acknowledge register bus.
 * Writes update the configuration flops and a write of 1 to the start
 * register gives a one-cycle seq_start pulse. Reads return the identification
 * words, every configuration register and the live busy bit. Both kinds of
 * request are acknowledged one cycle after the request.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fsrc_seq_config.svh"

module fsrc_seq_regmap (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         up_wreq,
  input  fsrc_seq_pkg::up_addr_t                       up_waddr,
  input  fsrc_seq_pkg::up_data_t                       up_wdata,
  output logic                                         up_wack,
  input  logic                                         up_rreq,
  input  fsrc_seq_pkg::up_addr_t                       up_raddr,
  output fsrc_seq_pkg::up_data_t                       up_rdata,
  output logic                                         up_rack,
  input  logic                                         busy,
  output logic                                         seq_start,
  output logic                                         seq_en,
  output logic                                         ext_trig_en,
  output logic                                         non_fsrc_delay_en,
  output fsrc_seq_pkg::seq_cnt_t                       ctrl_change_cnt,
  output fsrc_seq_pkg::seq_cnt_t                       accum_reset_cnt,
  output fsrc_seq_pkg::seq_cnt_t                       rx_delay_cnt,
  output fsrc_seq_pkg::seq_cnt_t [`FSRC_NUM_TRIG-1:0]  first_trig_cnt,
  output fsrc_seq_pkg::ctrl_word_t                     next_ctrl_value,
  output fsrc_seq_pkg::trig_vec_t                      manual_trig
);

  // Scratch word for software to check bus access
  fsrc_seq_pkg::up_data_t  scratch;

  // One select bit for each first trigger offset register
  fsrc_seq_pkg::trig_vec_t first_trig_wsel;
  fsrc_seq_pkg::trig_vec_t first_trig_rsel;

  // Read data of the first trigger offset block and of the whole map
  fsrc_seq_pkg::up_data_t  first_trig_rdata;
  fsrc_seq_pkg::up_data_t  rdata_mux;

  // ******************************
  // Address decode of the offset block
  // ******************************

  // The first trigger offsets sit at consecutive words from the base address
  always_comb begin
    first_trig_rdata = '0;
    for (int i = 0; i < `FSRC_NUM_TRIG; i++) begin
      first_trig_wsel[i] = up_wreq &&
                           (up_waddr == fsrc_seq_pkg::up_addr_t'(`REG_FIRST_TRIG_BASE + i));
      first_trig_rsel[i] = (up_raddr == fsrc_seq_pkg::up_addr_t'(`REG_FIRST_TRIG_BASE + i));
      if (first_trig_rsel[i]) begin
        first_trig_rdata = fsrc_seq_pkg::up_data_t'(first_trig_cnt[i]);
      end
    end
  end

  // ******************************
  // Write side
  // ******************************

  always_ff @(posedge clk) begin
    if (rst) begin
      up_wack           <= 1'b0;
      seq_start         <= 1'b0;
      scratch           <= '0;
      seq_en            <= 1'b0;
      ext_trig_en       <= 1'b0;
      non_fsrc_delay_en <= 1'b0;
      ctrl_change_cnt   <= '0;
      accum_reset_cnt   <= '0;
      rx_delay_cnt      <= '0;
      manual_trig       <= '0;
      first_trig_cnt    <= '0;
      next_ctrl_value   <= '0;
    end else begin
      // Every write is acknowledged, mapped or not
      up_wack <= up_wreq;
      // The start pulse clears itself one cycle later
      seq_start <= up_wreq && (up_waddr == `REG_START) && up_wdata[0];
      if (up_wreq) begin
        case (up_waddr)
          `REG_SCRATCH: begin
            scratch <= up_wdata;
          end
          `REG_CONTROL: begin
            seq_en            <= up_wdata[0];
            ext_trig_en       <= up_wdata[1];
            non_fsrc_delay_en <= up_wdata[2];
          end
          `REG_CTRL_CHANGE_CNT: begin
            ctrl_change_cnt <= up_wdata[`FSRC_COUNTER_WIDTH-1:0];
          end
          `REG_ACCUM_RESET_CNT: begin
            accum_reset_cnt <= up_wdata[`FSRC_COUNTER_WIDTH-1:0];
          end
          `REG_RX_DELAY_CNT: begin
            rx_delay_cnt <= up_wdata[`FSRC_COUNTER_WIDTH-1:0];
          end
          `REG_TRIG_MANUAL: begin
            manual_trig <= up_wdata[`FSRC_NUM_TRIG-1:0];
          end
          // The control word is staged in two halves
          `REG_NEXT_CTRL_LO: begin
            next_ctrl_value[31:0] <= up_wdata;
          end
          `REG_NEXT_CTRL_HI: begin
            next_ctrl_value[`FSRC_CTRL_WIDTH-1:32] <= up_wdata[`FSRC_CTRL_WIDTH-33:0];
          end
          // Read-only and unmapped words are left untouched
          default: begin
          end
        endcase
      end
      for (int i = 0; i < `FSRC_NUM_TRIG; i++) begin
        if (first_trig_wsel[i]) begin
          first_trig_cnt[i] <= up_wdata[`FSRC_COUNTER_WIDTH-1:0];
        end
      end
    end
  end

  // ******************************
  // Read side
  // ******************************

  always_comb begin
    case (up_raddr)
      `REG_VERSION:         rdata_mux = `FSRC_CORE_VERSION;
      `REG_MAGIC:           rdata_mux = `FSRC_CORE_MAGIC;
      `REG_SCRATCH:         rdata_mux = scratch;
      `REG_CONTROL:         rdata_mux = {29'd0, non_fsrc_delay_en, ext_trig_en, seq_en};
      `REG_CTRL_CHANGE_CNT: rdata_mux = fsrc_seq_pkg::up_data_t'(ctrl_change_cnt);
      `REG_ACCUM_RESET_CNT: rdata_mux = fsrc_seq_pkg::up_data_t'(accum_reset_cnt);
      `REG_RX_DELAY_CNT:    rdata_mux = fsrc_seq_pkg::up_data_t'(rx_delay_cnt);
      `REG_TRIG_MANUAL:     rdata_mux = fsrc_seq_pkg::up_data_t'(manual_trig);
      `REG_NEXT_CTRL_LO:    rdata_mux = next_ctrl_value[31:0];
      `REG_NEXT_CTRL_HI: begin
        rdata_mux = fsrc_seq_pkg::up_data_t'(next_ctrl_value[`FSRC_CTRL_WIDTH-1:32]);
      end
      `REG_STATUS:          rdata_mux = fsrc_seq_pkg::up_data_t'(busy);
      // Offset block or zero for any unmapped word, start included
      default:              rdata_mux = first_trig_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      up_rack <= 1'b0;
    end else begin
      up_rack <= up_rreq;
    end
  end

  // Read data is only meaningful together with up_rack
  always_ff @(posedge clk) begin
    up_rdata <= up_rreq ? rdata_mux : '0;
  end

endmodule

`default_nettype wire

// File: src/tx_fsrc_ctrl.sv
/*
 * Sequencer controller. A seq_start pulse arms it, the next rising edge of
 * the selected timing source starts the event counter, and the counter is
 * decoded into one-cycle event pulses. The staged control word is loaded onto
 * ctrl at its programmed count. trig_out carries either the sequencer pulses
 * or the manual trigger value.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fsrc_seq_config.svh"

module tx_fsrc_ctrl (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         sysref,
  input  logic                                         trig_in,
  input  logic                                         seq_start,
  input  logic                                         seq_en,
  input  logic                                         ext_trig_en,
  input  fsrc_seq_pkg::seq_cnt_t                       ctrl_change_cnt,
  input  fsrc_seq_pkg::seq_cnt_t                       accum_reset_cnt,
  input  fsrc_seq_pkg::seq_cnt_t                       rx_delay_cnt,
  input  fsrc_seq_pkg::seq_cnt_t [`FSRC_NUM_TRIG-1:0]  first_trig_cnt,
  input  fsrc_seq_pkg::ctrl_word_t                     next_ctrl_value,
  input  fsrc_seq_pkg::trig_vec_t                      manual_trig,
  output fsrc_seq_pkg::trig_vec_t                      trig_out,
  output logic                                         tx_data_start,
  output logic                                         rx_data_start,
  output fsrc_seq_pkg::ctrl_word_t                     ctrl,
  output logic                                         busy
);

  // Last count of a sequence, after which the controller goes idle
  localparam fsrc_seq_pkg::seq_cnt_t CNT_LAST = '1;

  // Controller state and event counter
  fsrc_seq_pkg::seq_state_t state;
  fsrc_seq_pkg::seq_cnt_t   count;

  // Two-flop synchronizer for the external trigger
  logic trig_in_m1;
  logic trig_in_m2;

  // Selected timing source, its previous sample and the detected rise
  logic trig_src;
  logic trig_src_d;
  logic trig_det;

  // High while the counter runs
  logic run;

  // Sequencer pulses for the trigger outputs
  fsrc_seq_pkg::trig_vec_t seq_trig;

  // Load strobe of the control word register
  logic ctrl_load;

  // ******************************
  // Trigger source and edge detect
  // ******************************

  // trig_in comes from outside the clk domain
  always_ff @(posedge clk) begin
    if (rst) begin
      trig_in_m1 <= 1'b0;
      trig_in_m2 <= 1'b0;
    end else begin
      trig_in_m1 <= trig_in;
      trig_in_m2 <= trig_in_m1;
    end
  end

  // sysref is already in the clk domain and is used as it is
  assign trig_src = ext_trig_en ? trig_in_m2 : sysref;

  // Keep the sample of the previous edge for the rise detect
  always_ff @(posedge clk) begin
    if (rst) begin
      trig_src_d <= 1'b0;
    end else begin
      trig_src_d <= trig_src;
    end
  end

  // A rise is high at this edge and was low at the edge before
  assign trig_det = trig_src & ~trig_src_d;

  // ******************************
  // State machine and event counter
  // ******************************

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fsrc_seq_pkg::SEQ_IDLE;
      count <= '0;
    end else begin
      case (state)
        fsrc_seq_pkg::SEQ_IDLE: begin
          count <= '0;
          // A start pulse in any other state is dropped
          if (seq_start) begin
            state <= fsrc_seq_pkg::SEQ_ARMED;
          end
        end
        fsrc_seq_pkg::SEQ_ARMED: begin
          // The detect edge itself is count zero
          if (trig_det) begin
            state <= fsrc_seq_pkg::SEQ_RUN;
            count <= '0;
          end
        end
        fsrc_seq_pkg::SEQ_RUN: begin
          if (count == CNT_LAST) begin
            state <= fsrc_seq_pkg::SEQ_IDLE;
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end
        default: begin
          state <= fsrc_seq_pkg::SEQ_IDLE;
          count <= '0;
        end
      endcase
    end
  end

  assign run  = (state == fsrc_seq_pkg::SEQ_RUN);
  assign busy = (state != fsrc_seq_pkg::SEQ_IDLE);

  // ******************************
  // Event pulses
  // ******************************

  // Each count value occurs once per run so every pulse lasts one cycle
  always_comb begin
    for (int i = 0; i < `FSRC_NUM_TRIG; i++) begin
      seq_trig[i] = run && (count == first_trig_cnt[i]);
    end
  end

  assign tx_data_start = run && (count == accum_reset_cnt);
  assign rx_data_start = run && (count == rx_delay_cnt);

  // Manual value is shown when sequencing is off
  assign trig_out = seq_en ? seq_trig : manual_trig;

  // ******************************
  // Control word register
  // ******************************

  // The new word appears in the cycle after the programmed count
  assign ctrl_load = run && (count == ctrl_change_cnt);

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl <= '0;
    end else if (ctrl_load) begin
      ctrl <= next_ctrl_value;
    end
  end

endmodule

`default_nettype wire

// File: src/axi_fsrc_sequencer.sv
/*
 * Top level of the sequencer. It connects the register map on the
 * request/acknowledge bus to the controller, all in the clk domain.
 * seq_debug shows that a sequence is armed or running.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fsrc_seq_config.svh"

module axi_fsrc_sequencer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      sysref,
  input  logic                      trig_in,
  output fsrc_seq_pkg::trig_vec_t   trig_out,
  output logic                      rx_data_start,
  output logic                      tx_data_start,
  output fsrc_seq_pkg::ctrl_word_t  ctrl,
  output logic                      tx_sequencer_non_fsrc_delay_en,
  output logic                      seq_debug,
  input  logic                      up_wreq,
  input  fsrc_seq_pkg::up_addr_t    up_waddr,
  input  fsrc_seq_pkg::up_data_t    up_wdata,
  output logic                      up_wack,
  input  logic                      up_rreq,
  input  fsrc_seq_pkg::up_addr_t    up_raddr,
  output fsrc_seq_pkg::up_data_t    up_rdata,
  output logic                      up_rack
);

  // ******************************
  // Configuration from the register map
  // ******************************
  logic                                         seq_start_s;
  logic                                         seq_en_s;
  logic                                         ext_trig_en_s;
  fsrc_seq_pkg::seq_cnt_t                       ctrl_change_cnt_s;
  fsrc_seq_pkg::seq_cnt_t                       accum_reset_cnt_s;
  fsrc_seq_pkg::seq_cnt_t                       rx_delay_cnt_s;
  fsrc_seq_pkg::seq_cnt_t [`FSRC_NUM_TRIG-1:0]  first_trig_cnt_s;
  fsrc_seq_pkg::ctrl_word_t                     next_ctrl_value_s;
  fsrc_seq_pkg::trig_vec_t                      manual_trig_s;

  // Busy from the controller feeds the status register and seq_debug
  logic                                         seq_busy_s;

  assign seq_debug = seq_busy_s;

  fsrc_seq_regmap i_regmap (
    .clk               (clk),
    .rst               (rst),
    .up_wreq           (up_wreq),
    .up_waddr          (up_waddr),
    .up_wdata          (up_wdata),
    .up_wack           (up_wack),
    .up_rreq           (up_rreq),
    .up_raddr          (up_raddr),
    .up_rdata          (up_rdata),
    .up_rack           (up_rack),
    .busy              (seq_busy_s),
    .seq_start         (seq_start_s),
    .seq_en            (seq_en_s),
    .ext_trig_en       (ext_trig_en_s),
    .non_fsrc_delay_en (tx_sequencer_non_fsrc_delay_en),
    .ctrl_change_cnt   (ctrl_change_cnt_s),
    .accum_reset_cnt   (accum_reset_cnt_s),
    .rx_delay_cnt      (rx_delay_cnt_s),
    .first_trig_cnt    (first_trig_cnt_s),
    .next_ctrl_value   (next_ctrl_value_s),
    .manual_trig       (manual_trig_s));

  tx_fsrc_ctrl tx_fsrc_sequencer (
    .clk             (clk),
    .rst             (rst),
    .sysref          (sysref),
    .trig_in         (trig_in),
    .seq_start       (seq_start_s),
    .seq_en          (seq_en_s),
    .ext_trig_en     (ext_trig_en_s),
    .ctrl_change_cnt (ctrl_change_cnt_s),
    .accum_reset_cnt (accum_reset_cnt_s),
    .rx_delay_cnt    (rx_delay_cnt_s),
    .first_trig_cnt  (first_trig_cnt_s),
    .next_ctrl_value (next_ctrl_value_s),
    .manual_trig     (manual_trig_s),
    .trig_out        (trig_out),
    .tx_data_start   (tx_data_start),
    .rx_data_start   (rx_data_start),
    .ctrl            (ctrl),
    .busy            (seq_busy_s));

endmodule

`default_nettype wire

// File: tb/tb_fsrc_seq.sv
/*
 * Self-checking testbench of the sample-rate-change sequencer. It drives the
 * register bus and the timing inputs of the top level, and a negedge monitor
 * records the edge index of every event pulse. The expected edges come from a
 * reference function of the programmed offsets. Run it through tb.f.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fsrc_seq_config.svh"

module tb_fsrc_seq;

  // Trigger outputs plus tx_data_start and rx_data_start
  localparam int NUM_PULSE = `FSRC_NUM_TRIG + 2;
  // Edges from the detect edge until the controller is idle again
  localparam int RUN_LEN = 1 << `FSRC_COUNTER_WIDTH;

  logic clk;
  logic rst;
  logic sysref;
  logic trig_in;
  logic up_wreq;
  fsrc_seq_pkg::up_addr_t up_waddr;
  fsrc_seq_pkg::up_data_t up_wdata;
  logic up_wack;
  logic up_rreq;
  fsrc_seq_pkg::up_addr_t up_raddr;
  fsrc_seq_pkg::up_data_t up_rdata;
  logic up_rack;
  fsrc_seq_pkg::trig_vec_t trig_out;
  logic rx_data_start;
  logic tx_data_start;
  fsrc_seq_pkg::ctrl_word_t ctrl;
  logic tx_sequencer_non_fsrc_delay_en;
  logic seq_debug;

  // Bookkeeping of the monitor and the checks
  int cyc;
  int errors;
  int checks;
  int tests;
  int seed = 52;
  bit mon_on;
  bit exp_on;
  int exp_edge [NUM_PULSE];
  int hit_cnt [NUM_PULSE];
  int ctrl_edge;
  int fall_edge;
  fsrc_seq_pkg::ctrl_word_t ctrl_prev;
  logic debug_prev;
  logic [NUM_PULSE-1:0] pulse_vec;

  // Offsets of the current sequence, trigger bits first, then tx and rx
  int offs [NUM_PULSE];
  int chg_off;
  fsrc_seq_pkg::ctrl_word_t staged;

  assign pulse_vec = {rx_data_start, tx_data_start, trig_out};

  axi_fsrc_sequencer u_dut (
    .clk                            (clk),
    .rst                            (rst),
    .sysref                         (sysref),
    .trig_in                        (trig_in),
    .trig_out                       (trig_out),
    .rx_data_start                  (rx_data_start),
    .tx_data_start                  (tx_data_start),
    .ctrl                           (ctrl),
    .tx_sequencer_non_fsrc_delay_en (tx_sequencer_non_fsrc_delay_en),
    .seq_debug                      (seq_debug),
    .up_wreq                        (up_wreq),
    .up_waddr                       (up_waddr),
    .up_wdata                       (up_wdata),
    .up_wack                        (up_wack),
    .up_rreq                        (up_rreq),
    .up_raddr                       (up_raddr),
    .up_rdata                       (up_rdata),
    .up_rack                        (up_rack));

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Edge index, so cyc at a negedge names the rising edge just before it
  always @(posedge clk) begin
    cyc = cyc + 1;
  end

  // ******************************
  // Reference model and helpers
  // ******************************

  // Edge after which an event is seen. The source rise is sampled at rise_edge,
  // and the trig_in synchronizer adds two edges before detection
  function automatic int expected_edge(input int rise_edge, input int offset, input bit ext);
    expected_edge = rise_edge + (ext ? 2 : 0) + offset;
  endfunction

  function automatic string pulse_name(input int j);
    if (j < `FSRC_NUM_TRIG) begin
      pulse_name = $sformatf("trig_out[%0d]", j);
    end else if (j == `FSRC_NUM_TRIG) begin
      pulse_name = "tx_data_start";
    end else begin
      pulse_name = "rx_data_start";
    end
  endfunction

  task automatic check_eq(input string name, input logic [63:0] expv, input logic [63:0] actv);
    checks = checks + 1;
    if (actv !== expv) begin
      errors = errors + 1;
      $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
               $time, name, expv, actv);
    end
  endtask

  task automatic report_error(input string msg);
    errors = errors + 1;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // Inputs change 5 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic reg_write(input fsrc_seq_pkg::up_addr_t addr, input fsrc_seq_pkg::up_data_t data);
    int n;
    step_cycle();
    up_wreq = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    step_cycle();
    up_wreq = 1'b0;
    n = 0;
    while (!up_wack && n < 10) begin
      step_cycle();
      n = n + 1;
    end
    if (!up_wack) begin
      report_error($sformatf("no write acknowledge for address %0h", addr));
    end
  endtask

  task automatic reg_read(input fsrc_seq_pkg::up_addr_t addr, output fsrc_seq_pkg::up_data_t data);
    int n;
    step_cycle();
    up_rreq = 1'b1;
    up_raddr = addr;
    step_cycle();
    up_rreq = 1'b0;
    n = 0;
    while (!up_rack && n < 10) begin
      step_cycle();
      n = n + 1;
    end
    data = up_rdata;
    if (!up_rack) begin
      report_error($sformatf("no read acknowledge for address %0h", addr));
    end
  endtask

  task automatic wait_idle(input int max_cycles);
    int n;
    n = 0;
    while (seq_debug && n < max_cycles) begin
      step_cycle();
      n = n + 1;
    end
    if (seq_debug) begin
      report_error("sequencer did not return to idle");
    end
  endtask

  // Draws new offsets and a new staged word and writes them to the DUT
  task automatic program_random();
    logic [31:0] lo;
    logic [31:0] hi;
    for (int j = 0; j < NUM_PULSE; j++) begin
      offs[j] = $random(seed) & (RUN_LEN - 1);
    end
    chg_off = $random(seed) & (RUN_LEN - 1);
    lo = $random(seed);
    hi = $random(seed);
    staged = {hi[`FSRC_CTRL_WIDTH-33:0], lo};
    // A word equal to the current ctrl would hide the load edge
    if (staged == ctrl) begin
      staged[0] = ~staged[0];
    end
    for (int j = 0; j < `FSRC_NUM_TRIG; j++) begin
      reg_write(fsrc_seq_pkg::up_addr_t'(`REG_FIRST_TRIG_BASE + j), 32'(offs[j]));
    end
    reg_write(`REG_ACCUM_RESET_CNT, 32'(offs[`FSRC_NUM_TRIG]));
    reg_write(`REG_RX_DELAY_CNT, 32'(offs[`FSRC_NUM_TRIG+1]));
    reg_write(`REG_CTRL_CHANGE_CNT, 32'(chg_off));
    reg_write(`REG_NEXT_CTRL_LO, staged[31:0]);
    reg_write(`REG_NEXT_CTRL_HI, 32'(staged[`FSRC_CTRL_WIDTH-1:32]));
  endtask

  // ******************************
  // Pulse monitor
  // ******************************

  // Sampled at the falling edge where every output has settled
  always @(negedge clk) begin
    if (mon_on) begin
      for (int j = 0; j < NUM_PULSE; j++) begin
        if (pulse_vec[j]) begin
          hit_cnt[j] = hit_cnt[j] + 1;
          if (exp_on) begin
            check_eq(pulse_name(j), 64'(exp_edge[j]), 64'(cyc));
          end else begin
            report_error($sformatf("%s pulsed with no sequence running", pulse_name(j)));
          end
        end
      end
      if (ctrl !== ctrl_prev && ctrl_edge < 0) begin
        ctrl_edge = cyc;
      end
      if (debug_prev && !seq_debug) begin
        fall_edge = cyc;
      end
    end
    ctrl_prev = ctrl;
    debug_prev = seq_debug;
  end

  // Starts a sequence, fires the selected source and checks every event edge
  task automatic run_sequence(input bit ext, input bit restart);
    int rise;
    fsrc_seq_pkg::up_data_t rd;
    for (int j = 0; j < NUM_PULSE; j++) begin
      hit_cnt[j] = 0;
    end
    ctrl_edge = -1;
    fall_edge = -1;
    reg_write(`REG_START, 32'd1);
    // One more edge for seq_start to arm the controller
    step_cycle();
    check_eq("seq_debug", 64'd1, 64'(seq_debug));
    reg_read(`REG_STATUS, rd);
    check_eq("status busy", 64'd1, 64'(rd[0]));
    if (ext) begin
      // With the external trigger selected a sysref rise must do nothing
      // A run started by it would already be over when this wait ends
      sysref = 1'b1;
      repeat (2) step_cycle();
      sysref = 1'b0;
      repeat (20) step_cycle();
      check_eq("seq_debug", 64'd1, 64'(seq_debug));
    end
    step_cycle();
    rise = cyc + 1;
    for (int j = 0; j < NUM_PULSE; j++) begin
      exp_edge[j] = expected_edge(rise, offs[j], ext);
    end
    exp_on = 1'b1;
    if (ext) begin
      trig_in = 1'b1;
    end else begin
      sysref = 1'b1;
    end
    repeat (2) step_cycle();
    sysref = 1'b0;
    trig_in = 1'b0;
    if (restart) begin
      reg_write(`REG_START, 32'd1);
    end
    wait_idle(4 * RUN_LEN);
    step_cycle();
    for (int j = 0; j < NUM_PULSE; j++) begin
      check_eq({pulse_name(j), " count"}, 64'd1, 64'(hit_cnt[j]));
    end
    check_eq("ctrl load edge", 64'(expected_edge(rise, chg_off + 1, ext)), 64'(ctrl_edge));
    check_eq("ctrl", 64'(staged), 64'(ctrl));
    check_eq("seq_debug fall edge", 64'(expected_edge(rise, RUN_LEN, ext)), 64'(fall_edge));
    exp_on = 1'b0;
  endtask

  task automatic end_test(input string name);
    tests = tests + 1;
    $display("test %0d %s finished, errors so far %0d", tests, name, errors);
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    fsrc_seq_pkg::up_data_t rd;
    rst = 1'b1;
    sysref = 1'b0;
    trig_in = 1'b0;
    up_wreq = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    up_rreq = 1'b0;
    up_raddr = '0;
    cyc = 0;
    errors = 0;
    checks = 0;
    tests = 0;
    mon_on = 1'b0;
    exp_on = 1'b0;
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;

    // Reset values and identification
    check_eq("trig_out", 64'd0, 64'(trig_out));
    check_eq("tx_data_start", 64'd0, 64'(tx_data_start));
    check_eq("rx_data_start", 64'd0, 64'(rx_data_start));
    check_eq("seq_debug", 64'd0, 64'(seq_debug));
    check_eq("ctrl", 64'd0, 64'(ctrl));
    check_eq("up_wack", 64'd0, 64'(up_wack));
    check_eq("up_rack", 64'd0, 64'(up_rack));
    reg_read(`REG_VERSION, rd);
    check_eq("version", 64'(`FSRC_CORE_VERSION), 64'(rd));
    reg_read(`REG_MAGIC, rd);
    check_eq("magic", 64'(`FSRC_CORE_MAGIC), 64'(rd));
    reg_write(`REG_SCRATCH, 32'hA5C3_0F96);
    reg_read(`REG_SCRATCH, rd);
    check_eq("scratch", 64'h0000_0000_A5C3_0F96, 64'(rd));
    end_test("reset and identification");

    // Manual trigger value with sequencing off
    reg_write(`REG_CONTROL, 32'd0);
    reg_write(`REG_TRIG_MANUAL, 32'h5);
    step_cycle();
    check_eq("trig_out", 64'h5, 64'(trig_out));
    reg_write(`REG_TRIG_MANUAL, 32'hA);
    step_cycle();
    check_eq("trig_out", 64'hA, 64'(trig_out));
    reg_write(`REG_CONTROL, 32'h4);
    step_cycle();
    check_eq("tx_sequencer_non_fsrc_delay_en", 64'd1, 64'(tx_sequencer_non_fsrc_delay_en));
    reg_write(`REG_CONTROL, 32'd0);
    reg_write(`REG_TRIG_MANUAL, 32'd0);
    step_cycle();
    check_eq("tx_sequencer_non_fsrc_delay_en", 64'd0, 64'(tx_sequencer_non_fsrc_delay_en));
    end_test("manual trigger and delay enable");

    // Sysref-triggered sequence
    reg_write(`REG_CONTROL, 32'h1);
    program_random();
    mon_on = 1'b1;
    sysref = 1'b1;
    repeat (2) step_cycle();
    sysref = 1'b0;
    repeat (20) step_cycle();
    check_eq("seq_debug", 64'd0, 64'(seq_debug));
    run_sequence(1'b0, 1'b0);
    end_test("sysref sequence");

    // External trigger sequence
    reg_write(`REG_CONTROL, 32'h3);
    program_random();
    run_sequence(1'b1, 1'b0);
    end_test("external trigger sequence");

    // A start during a run is dropped, a start after idle runs again
    reg_write(`REG_CONTROL, 32'h1);
    program_random();
    run_sequence(1'b0, 1'b1);
    repeat (5) step_cycle();
    check_eq("seq_debug", 64'd0, 64'(seq_debug));
    program_random();
    run_sequence(1'b0, 1'b0);
    end_test("restart during run");

    $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
src/fsrc_seq_pkg.sv
src/fsrc_seq_regmap.sv
src/tx_fsrc_ctrl.sv
src/axi_fsrc_sequencer.sv
tb/tb_fsrc_seq.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  -f tb.f \
  --top-module tb_fsrc_seq \
  -Mdir obj_dir \
  -o sim_tb_fsrc_seq

./obj_dir/sim_tb_fsrc_seq > sim.log 2>&1 || true
cat sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
